// ==== heapMemory.f ====
logic/heapPkg.sv
logic/heapAllocator.sv
logic/arrayBounds.sv
logic/elementDatapath.sv
logic/heapMemory.sv
testbench/heapMemoryTb.sv

// ==== logic/arrayBounds.sv ====
// Array sizes and the single legality decision for every heap operation.
// Produces accepted and the element index within the cycle, and
// registers the error code so it appears with out one cycle later.

module arrayBounds #(
  parameter int addressBits = 2,                     // Width of an array number
  parameter int indexBits   = 2                      // Width of an element index
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapPkg::heapOp         action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic                   arrayLive,          // From allocator
  input  logic                   allocFailed,        // From allocator
  input  logic [addressBits-1:0] allocResult,        // Array Alloc hands out
  output logic                   accepted,           // Legal, combinational
  output logic [indexBits-1:0]   elementIndex,       // Element the operation touches
  output logic [indexBits:0]     sizeValue,          // Size of addressed array
  output heapPkg::heapError      error               // Registered result code
);

  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam logic [indexBits:0] fullSize = (indexBits + 1)'(arrayLength);

  logic [indexBits:0]  sizes [arrays];               // Elements in use per array
  logic [indexBits:0]  indexWide;                    // Index with a spare top bit
  logic [indexBits:0]  sizeLess;                     // Size minus one, for Pop
  heapPkg::heapError   code;                         // Outcome of this cycle

  assign sizeValue = sizes[array];
  assign indexWide = {1'b0, index};
  assign sizeLess  = sizeValue - 1'b1;

  // -------------------------------------------------------------------------
  // Legality, first failing check wins
  // -------------------------------------------------------------------------
  always_comb begin
    code = heapPkg::None;
    if (action == heapPkg::Alloc) begin
      if (allocFailed) code = heapPkg::OutOfMemory;
    end else if (action != heapPkg::Idle) begin
      if (!arrayLive) begin
        code = heapPkg::NotLive;
      end else if ((action == heapPkg::Read || heapPkg::isElementOp(action)) &&
                   indexWide >= sizeValue) begin
        code = heapPkg::OutOfBounds;
      end else if (action == heapPkg::Push && sizeValue == fullSize) begin
        code = heapPkg::Full;
      end else if (action == heapPkg::Pop && sizeValue == '0) begin
        code = heapPkg::Empty;
      end
    end
  end

  assign accepted = action != heapPkg::Idle && code == heapPkg::None;

  // Push appends at size, Pop takes the last element
  always_comb begin
    case (action)
      heapPkg::Push: elementIndex = sizeValue[indexBits-1:0];
      heapPkg::Pop:  elementIndex = sizeLess[indexBits-1:0];
      default:       elementIndex = index;
    endcase
  end

  // -------------------------------------------------------------------------
  // Sizes and error register
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      error <= heapPkg::None;
      for (int a = 0; a < arrays; a++) begin
        sizes[a] <= '0;                              // All arrays empty
      end
    end else begin
      error <= code;                                 // Idle reports None
      if (accepted) begin
        case (action)
          heapPkg::Write: begin
            if (indexWide >= sizeValue) sizes[array] <= indexWide + 1'b1;   // Grow to cover index
          end
          heapPkg::Push:  sizes[array]       <= sizeValue + 1'b1;
          heapPkg::Pop:   sizes[array]       <= sizeLess;
          heapPkg::Alloc: sizes[allocResult] <= '0;  // New array starts empty
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== logic/elementDatapath.sv ====
// Element storage of the heap memory, one row per array, with the
// in-place arithmetic and logic updates and the registered out value.
// Acts only on operations that arrayBounds has accepted.

module elementDatapath #(
  parameter int addressBits = 2,                     // Width of an array number
  parameter int indexBits   = 2,                     // Width of an element index
  parameter int dataBits    = 12                     // Width of an element
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapPkg::heapOp         action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   elementIndex,       // Chosen by arrayBounds
  input  logic [dataBits-1:0]    in,
  input  logic                   accepted,
  input  logic [indexBits:0]     sizeValue,          // For Size
  input  logic [addressBits-1:0] allocResult,        // For Alloc
  output logic [dataBits-1:0]    out
);

  localparam int arrays      = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  logic [dataBits-1:0] storage [arrays][arrayLength];    // All elements of all arrays
  logic [dataBits-1:0] element;                      // Addressed element, old value
  logic [dataBits-1:0] newValue;                     // Value to store
  logic                storeElement;

  assign element = storage[array][elementIndex];

  // -------------------------------------------------------------------------
  // Update value, wraps at dataBits
  // -------------------------------------------------------------------------
  always_comb begin
    case (action)
      heapPkg::Add,
      heapPkg::AddAfter: newValue = element + in;
      heapPkg::Subtract,
      heapPkg::SubAfter: newValue = element - in;
      heapPkg::Or:       newValue = element | in;
      heapPkg::Xor:      newValue = element ^ in;
      heapPkg::And:      newValue = element & in;
      heapPkg::Not:      newValue = ~element;
      default:           newValue = in;              // Write and Push
    endcase
  end

  assign storeElement = accepted && (action == heapPkg::Write || action == heapPkg::Push ||
                                     heapPkg::isElementOp(action));

  // Storage, no reset
  always_ff @(posedge clock) begin
    if (storeElement) begin
      storage[array][elementIndex] <= newValue;
    end
  end

  // -------------------------------------------------------------------------
  // Out register, holds until an accepted operation reloads it
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out <= '0;
    end else if (accepted) begin
      case (action)
        heapPkg::Write:    out <= in;
        heapPkg::Read,
        heapPkg::Pop:      out <= element;           // Pop index already size minus one
        heapPkg::AddAfter,
        heapPkg::SubAfter: out <= element;           // Value before the update
        heapPkg::Add,
        heapPkg::Subtract,
        heapPkg::Or,
        heapPkg::Xor,
        heapPkg::And,
        heapPkg::Not:      out <= newValue;
        heapPkg::Size:     out <= dataBits'(sizeValue);      // Zero-extended
        heapPkg::Alloc:    out <= dataBits'(allocResult);    // Zero-extended
        default:           out <= out;               // Free and Push leave out alone
      endcase
    end
  end

endmodule

// ==== logic/heapAllocator.sv ====
// Allocation bookkeeping for the heap memory: live flag per array,
// a LIFO of freed array numbers and a counter of arrays never handed out.
// Updates only on operations that arrayBounds has accepted.

module heapAllocator #(
  parameter int addressBits = 2                      // Width of an array number
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapPkg::heapOp         action,             // Current operation
  input  logic [addressBits-1:0] array,              // Addressed array
  input  logic                   accepted,           // Operation passed all checks
  output logic                   arrayLive,          // Addressed array is allocated
  output logic                   allocFailed,        // Nothing left to hand out
  output logic [addressBits-1:0] allocResult         // Array that Alloc would return
);

  localparam int arrays = 2 ** addressBits;
  localparam logic [addressBits:0] counterEnd = (addressBits + 1)'(arrays);

  logic [arrays-1:0]      live;                      // One flag per array
  logic [addressBits-1:0] freeStack [arrays];        // Freed array numbers
  logic [addressBits:0]   freeTop;                   // Entries on the free stack
  logic [addressBits:0]   neverUsed;                 // Next fresh array number
  logic [addressBits-1:0] topEntry;                  // Slot of the newest freed array
  logic                   stackEmpty;
  logic                   takeAlloc;
  logic                   takeFree;

  // -------------------------------------------------------------------------
  // Status seen by the legality check, from registers only
  // -------------------------------------------------------------------------
  assign stackEmpty  = freeTop == '0;
  assign topEntry    = freeTop[addressBits-1:0] - 1'b1;    // Wraps right when stack full
  assign arrayLive   = live[array];
  assign allocFailed = stackEmpty && neverUsed == counterEnd;

  // Reuse freed arrays first, newest first
  assign allocResult = stackEmpty ? neverUsed[addressBits-1:0] : freeStack[topEntry];

  assign takeAlloc = accepted && action == heapPkg::Alloc;
  assign takeFree  = accepted && action == heapPkg::Free;

  // Free stack storage
  always_ff @(posedge clock) begin
    if (takeFree) begin
      freeStack[freeTop[addressBits-1:0]] <= array;  // Never overflows, only live arrays freed
    end
  end

  // -------------------------------------------------------------------------
  // Control state
  // -------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      live      <= '0;                               // Nothing allocated
      freeTop   <= '0;
      neverUsed <= '0;
    end else if (takeAlloc) begin
      if (stackEmpty) begin
        neverUsed <= neverUsed + 1'b1;               // Fresh array taken
      end else begin
        freeTop <= freeTop - 1'b1;                   // Reused array popped
      end
      live[allocResult] <= 1'b1;
    end else if (takeFree) begin
      freeTop     <= freeTop + 1'b1;
      live[array] <= 1'b0;                           // A second free now sees NotLive
    end
  end

endmodule

// ==== logic/heapMemory.sv ====
// Top level of the heap memory. Takes one operation per clock and
// returns out and error one cycle later. Sets the widths for all blocks.

module heapMemory #(
  parameter int addressBits = 2,                     // Four arrays
  parameter int indexBits   = 2,                     // Four elements per array
  parameter int dataBits    = 12                     // Element width
) (
  input  logic                   clock,
  input  logic                   reset,
  input  heapPkg::heapOp         action,             // Level opcode, Idle for none
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapPkg::heapError      error
);

  logic                   arrayLive;
  logic                   allocFailed;
  logic [addressBits-1:0] allocResult;
  logic                   accepted;
  logic [indexBits-1:0]   elementIndex;
  logic [indexBits:0]     sizeValue;

  // -------------------------------------------------------------------------
  // Allocation bookkeeping, sizes and legality, element storage
  // -------------------------------------------------------------------------
  heapAllocator #(.addressBits(addressBits)) allocator_i (
    .clock, .reset, .action, .array, .accepted,
    .arrayLive, .allocFailed, .allocResult
  );

  arrayBounds #(
    .addressBits(addressBits),
    .indexBits  (indexBits)
  ) bounds_i (
    .clock, .reset, .action, .array, .index,
    .arrayLive, .allocFailed, .allocResult,
    .accepted, .elementIndex, .sizeValue, .error
  );

  elementDatapath #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) datapath_i (
    .clock, .reset, .action, .array, .elementIndex, .in,
    .accepted, .sizeValue, .allocResult, .out
  );

endmodule

// ==== logic/heapPkg.sv ====
// Opcode and error-code definitions shared by every heap memory block.
// Blocks refer to these by scoped names through heapPkg.

package heapPkg;

  // -------------------------------------------------------------------------
  // Operations, one sampled per clock edge
  // -------------------------------------------------------------------------
  typedef enum logic [4:0] {
    Idle     = 5'd0,                                 // No operation
    Write    = 5'd1,                                 // Write an element, may grow size
    Read     = 5'd2,                                 // Read an element
    Size     = 5'd3,                                 // Current size of array
    Push     = 5'd4,                                 // Append to array
    Pop      = 5'd5,                                 // Remove last element
    Alloc    = 5'd6,                                 // Hand out an empty array
    Free     = 5'd7,                                 // Return array for reuse
    Add      = 5'd8,                                 // Add, return new value
    AddAfter = 5'd9,                                 // Add, return old value
    Subtract = 5'd10,                                // Subtract, return new value
    SubAfter = 5'd11,                                // Subtract, return old value
    Or       = 5'd12,                                // Bitwise or
    Xor      = 5'd13,                                // Bitwise xor
    And      = 5'd14,                                // Bitwise and
    Not      = 5'd15                                 // Bitwise invert, in ignored
  } heapOp;

  // -------------------------------------------------------------------------
  // Error codes, registered alongside out
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    None        = 3'd0,                              // Operation accepted
    NotLive     = 3'd1,                              // Array never allocated or freed
    OutOfBounds = 3'd2,                              // Index at or past size
    Full        = 3'd3,                              // Push on full array
    Empty       = 3'd4,                              // Pop on empty array
    OutOfMemory = 3'd5                               // No array left to allocate
  } heapError;

  // In-place element updates, Add through Not
  function automatic logic isElementOp(input heapOp op);
    return op inside {Add, AddAfter, Subtract, SubAfter, Or, Xor, And, Not};
  endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the heap memory testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module heapMemoryTb -f heapMemory.f -o heapMemorySim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/heapMemorySim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// ==== testbench/heapMemoryTb.sv ====
// Testbench for the heap memory. Replays operations from the vector file,
// one per clock, and checks out and error one cycle after each operation.
// Run from the project root so the vector file path resolves.

module heapMemoryTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int addressBits = 2;                    // Vector widths, match DUT defaults
  localparam int indexBits   = 2;
  localparam int dataBits    = 12;
  localparam int resetCycles = 5;

  logic                   clock;
  logic                   reset;
  heapPkg::heapOp         action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    in;
  logic [dataBits-1:0]    out;
  heapPkg::heapError      error;

  logic [4:0]             vecAction [$];             // One entry per vector line
  logic [addressBits-1:0] vecArray [$];
  logic [indexBits-1:0]   vecIndex [$];
  logic [dataBits-1:0]    vecIn [$];
  logic [dataBits-1:0]    vecOut [$];                // Expected out
  logic [2:0]             vecError [$];              // Expected error code

  int errors;
  int cycles;
  int cycleLimit;

  heapMemory dut_i (
    .clock, .reset, .action, .array, .index, .in, .out, .error
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;                      // 40 ns period
  end

  // Reports a value mismatch
  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0d ns %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    end
  endtask

  // -------------------------------------------------------------------------
  // Vector file reader, skips comment and blank lines
  // -------------------------------------------------------------------------
  task automatic loadVectors();
    int          fd;
    int          fields;
    int          lineNo;
    string       line;
    logic [31:0] a, b, c, d, e, f;
    fd = $fopen("testbench/heapVectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the vector file testbench/heapVectors.txt");
      return;
    end
    lineNo = 0;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;              // End of file
      lineNo++;
      if (line.len() <= 1 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%h %h %h %h %h %h", a, b, c, d, e, f);
      if (fields != 6) begin
        errors++;
        $display("Vector line %0d is malformed, it needs six hex fields", lineNo);
      end else begin
        vecAction.push_back(a[4:0]);
        vecArray.push_back(b[addressBits-1:0]);
        vecIndex.push_back(c[indexBits-1:0]);
        vecIn.push_back(d[dataBits-1:0]);
        vecOut.push_back(e[dataBits-1:0]);
        vecError.push_back(f[2:0]);
      end
    end
    $fclose(fd);
  endtask

  // Run limit, ends a stuck simulation
  always @(posedge clock) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout, the run went past %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // Stimulus and checks
  // -------------------------------------------------------------------------
  initial begin
    errors     = 0;
    cycles     = 0;
    reset      = 1'b1;
    action     = heapPkg::Idle;
    array      = '0;
    index      = '0;
    in         = '0;
    loadVectors();
    cycleLimit = vecAction.size() + resetCycles + 20;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;
    for (int k = 0; k <= vecAction.size(); k++) begin
      @(posedge clock);
      if (k < vecAction.size()) begin
        action <= heapPkg::heapOp'(vecAction[k]);
        array  <= vecArray[k];
        index  <= vecIndex[k];
        in     <= vecIn[k];
      end else begin
        action <= heapPkg::Idle;                     // Drain after last vector
      end
      if (k > 0) begin
        @(negedge clock);                            // Result of previous vector settled
        compare("out", 32'(vecOut[k-1]), 32'(out));
        compare("error", 32'(vecError[k-1]), 32'(error));
      end
    end
    $display("Ran %0d vectors with %0d errors", vecAction.size(), errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/heapVectors.txt ====
# action array index in expectedOut expectedError, all hex, one operation per line
# action and error codes use the heapPkg enum values
2 1 0 000 000 1
7 1 0 000 000 1
6 0 0 000 000 0
6 0 0 000 001 0
6 0 0 000 002 0
6 0 0 000 003 0
6 0 0 000 003 5
4 2 0 055 003 0
7 2 0 000 003 0
6 0 0 000 002 0
3 2 0 000 000 0
4 0 0 001 000 0
4 0 0 002 000 0
3 0 0 000 002 0
5 0 0 000 002 0
5 0 0 000 001 0
5 0 0 000 001 4
4 1 0 0a1 001 0
4 1 0 0a2 001 0
4 1 0 0a3 001 0
4 1 0 0a4 001 0
4 1 0 0a5 001 3
1 3 2 123 123 0
3 3 0 000 003 0
2 3 3 000 003 2
2 3 2 000 123 0
7 3 0 000 123 0
2 3 0 000 123 1
1 3 0 777 123 1
7 3 0 000 123 1
6 0 0 000 003 0
3 3 0 000 000 0
8 1 0 100 1a1 0
9 1 0 f00 1a1 0
2 1 0 000 0a1 0
a 1 1 0a3 fff 0
b 1 1 001 fff 0
2 1 1 000 ffe 0
8 0 0 001 ffe 2
c 1 2 5f0 5f3 0
d 1 2 0ff 50c 0
e 1 2 30e 10c 0
f 1 3 000 f5b 0
2 1 2 000 10c 0
0 0 0 000 10c 0
5 0 0 000 10c 4
0 0 0 000 10c 0
